// File: logic/led_matrix_macros.svh
// ====================
// panel geometry, color depth, APB map
// and plane timing constants
// ====================
`ifndef LED_MATRIX_MACROS_SVH
`define LED_MATRIX_MACROS_SVH

// panel geometry, one half of the panel
`define LM_COLS              16
`define LM_HALF_ROWS         8

// bits per channel, also the number of brightness planes
`define LM_COLOR_BITS        4

// plane 0 display time in clk_root cycles, doubles per plane
`define LM_PLANE_BASE_TICKS  4

// APB register map
`define LM_CTRL_ADDR         12'h400
`define LM_STATUS_ADDR       12'h404

`define LM_FRAME_CNT_BITS    16

`endif

// File: logic/led_matrix_pkg.sv
// ====================
// vector types and scan state enum
// ====================
`default_nettype none
`include "led_matrix_macros.svh"

package led_matrix_pkg;

    typedef logic [$clog2(`LM_COLS)-1:0]      col_t;
    typedef logic [$clog2(`LM_HALF_ROWS)-1:0] row_t;
    typedef logic [$clog2(`LM_COLOR_BITS)-1:0] plane_t;
    typedef logic [`LM_COLOR_BITS-1:0]        channel_t;
    typedef logic [3*`LM_COLOR_BITS-1:0]      pixel_t;      // {red, green, blue}

    // {half, row, col}, half 0 = top
    typedef logic [$clog2(`LM_HALF_ROWS)+$clog2(`LM_COLS):0] fb_addr_t;

    typedef logic [2:0]                       rgb_t;        // bit 0 red, 2 blue
    typedef logic [`LM_COLOR_BITS-1:0]        plane_mask_t;
    typedef logic [`LM_FRAME_CNT_BITS-1:0]    frame_cnt_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        LOAD,
        SHIFT_LOW,
        SHIFT_HIGH,
        BLANK,
        LATCH,
        DISPLAY
    } scan_state_t;

endpackage

`default_nettype wire

// File: logic/apb_regs.sv
// ====================
// APB slave with framebuffer window,
// control register and frame count status
// ====================
`default_nettype none
`include "led_matrix_macros.svh"

module apb_regs
    import led_matrix_pkg::*;
(
    input  wire               clk_root,
    input  wire               rst,
    input  wire               psel,
    input  wire               penable,
    input  wire               pwrite,
    input  wire        [11:0] paddr,
    input  wire        [31:0] pwdata,
    output logic       [31:0] prdata,
    output logic              pready,
    output logic              pslverr,
    output logic              fb_we,
    output fb_addr_t          fb_addr,
    output pixel_t            fb_wdata,
    input  wire pixel_t       fb_rdata,
    output rgb_t              rgb_enable,
    output plane_mask_t       plane_enable,
    input  wire frame_cnt_t   frame_count
);

    logic        access;
    logic        fb_hit;
    logic        ctrl_hit;
    logic        status_hit;
    logic        commit;     // last access cycle, writes land here
    logic [31:0] rd_word;

    assign access     = psel & penable;
    assign commit     = access & pready & pwrite;
    assign fb_hit     = (paddr[11:10] == 2'b00) && (paddr[1:0] == 2'b00);
    assign ctrl_hit   = (paddr == `LM_CTRL_ADDR);
    assign status_hit = (paddr == `LM_STATUS_ADDR);

    // framebuffer read runs off the setup-phase address
    assign fb_addr  = paddr[9:2];
    assign fb_wdata = pwdata[$bits(pixel_t)-1:0];
    assign fb_we    = commit & fb_hit;

    always_comb begin
        rd_word = '0;
        if (fb_hit) begin
            rd_word[$bits(pixel_t)-1:0] = fb_rdata;
        end else if (ctrl_hit) begin
            rd_word[2:0] = rgb_enable;
            rd_word[7:4] = plane_enable;
        end else if (status_hit) begin
            rd_word[$bits(frame_cnt_t)-1:0] = frame_count;
        end
    end

    // one wait state, pready in the second access cycle
    always_ff @(posedge clk_root) begin
        if (rst) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end else begin
            pready  <= access & ~pready;
            pslverr <= access & ~pready & ~(fb_hit | ctrl_hit | status_hit);
        end
    end

    always_ff @(posedge clk_root) begin
        if (access && !pready) begin
            prdata <= rd_word;
        end
    end

    always_ff @(posedge clk_root) begin
        if (rst) begin
            rgb_enable   <= '1;
            plane_enable <= '1;
        end else if (commit && ctrl_hit) begin
            rgb_enable   <= pwdata[2:0];
            plane_enable <= pwdata[7:4];
        end
    end

endmodule

`default_nettype wire

// File: logic/framebuffer.sv
// ====================
// pixel memory, APB port plus two scan read ports
// ====================
`default_nettype none
`include "led_matrix_macros.svh"

module framebuffer
    import led_matrix_pkg::*;
(
    input  wire             clk_root,
    input  wire             rst,
    input  wire             we,
    input  wire fb_addr_t   addr,
    input  wire pixel_t     wdata,
    output pixel_t          rdata,
    input  wire fb_addr_t   top_addr,
    input  wire fb_addr_t   bottom_addr,
    output pixel_t          top_data,
    output pixel_t          bottom_data
);

    localparam int DEPTH = 2 * `LM_HALF_ROWS * `LM_COLS;

    pixel_t mem [DEPTH];

    always_ff @(posedge clk_root) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;   // blank image
            end
        end else if (we) begin
            mem[addr] <= wdata;
        end
    end

    // all three reads registered
    always_ff @(posedge clk_root) begin
        rdata       <= mem[addr];
        top_data    <= mem[top_addr];
        bottom_data <= mem[bottom_addr];
    end

endmodule

`default_nettype wire

// File: logic/plane_timer.sv
// ====================
// binary-weighted display time per plane
// ====================
`default_nettype none
`include "led_matrix_macros.svh"

module plane_timer
    import led_matrix_pkg::*;
(
    input  wire           clk_root,
    input  wire           rst,
    input  wire           start,
    input  wire plane_t   plane,
    output logic          done
);

    localparam int MAX_TICKS = `LM_PLANE_BASE_TICKS << (`LM_COLOR_BITS - 1);
    localparam int CNT_W     = $clog2(MAX_TICKS + 1);

    logic [CNT_W-1:0] count;    // zero when idle

    always_ff @(posedge clk_root) begin
        if (rst) begin
            count <= '0;
        end else if (count != '0) begin
            count <= count - 1'b1;  // start ignored while busy
        end else if (start) begin
            count <= CNT_W'(`LM_PLANE_BASE_TICKS) << plane;
        end
    end

    // count of 1 falls exactly N cycles after start
    assign done = (count == CNT_W'(1));

endmodule

`default_nettype wire

// File: logic/pixel_fetch.sv
// ====================
// framebuffer addressing and per-plane
// bit split of the top/bottom pixel pair
// ====================
`default_nettype none
`include "led_matrix_macros.svh"

module pixel_fetch
    import led_matrix_pkg::*;
(
    input  wire                clk_root,
    input  wire                rst,
    input  wire col_t          col,
    input  wire row_t          row,
    input  wire plane_t        plane,
    input  wire                fetch,
    input  wire                load,
    input  wire rgb_t          rgb_enable,
    input  wire plane_mask_t   plane_enable,
    output fb_addr_t           top_addr,
    output fb_addr_t           bottom_addr,
    input  wire pixel_t        top_data,
    input  wire pixel_t        bottom_data,
    output rgb_t               rgb_top,
    output rgb_t               rgb_bottom
);

    // pick one plane bit from each channel, then apply the enables
    function automatic rgb_t plane_bits(input pixel_t px, input plane_t pl,
                                        input rgb_t chan_en, input logic plane_on);
        channel_t red;
        channel_t green;
        channel_t blue;
        rgb_t     bits;
        red   = px[3*`LM_COLOR_BITS-1 -: `LM_COLOR_BITS];
        green = px[2*`LM_COLOR_BITS-1 -: `LM_COLOR_BITS];
        blue  = px[`LM_COLOR_BITS-1:0];
        bits  = {blue[pl], green[pl], red[pl]};
        return bits & chan_en & {3{plane_on}};
    endfunction

    always_ff @(posedge clk_root) begin
        if (rst) begin
            top_addr    <= '0;
            bottom_addr <= '0;
        end else if (fetch) begin
            top_addr    <= {1'b0, row, col};
            bottom_addr <= {1'b1, row, col};    // lower half of the panel
        end
    end

    always_ff @(posedge clk_root) begin
        if (rst) begin
            rgb_top    <= '0;
            rgb_bottom <= '0;
        end else if (load) begin
            rgb_top    <= plane_bits(top_data, plane, rgb_enable, plane_enable[plane]);
            rgb_bottom <= plane_bits(bottom_data, plane, rgb_enable, plane_enable[plane]);
        end
    end

endmodule

`default_nettype wire

// File: logic/matrix_scan.sv
// ====================
// scan FSM for columns, latch, display,
// planes, rows and the frame count
// ====================
`default_nettype none
`include "led_matrix_macros.svh"

module matrix_scan
    import led_matrix_pkg::*;
(
    input  wire          clk_root,
    input  wire          rst,
    input  wire          timer_done,
    output col_t         col,
    output row_t         row,
    output plane_t       plane,
    output logic         fetch,
    output logic         load,
    output logic         timer_start,
    output logic         clk_pixel,
    output logic         row_latch,
    output logic         oe_n,
    output row_t         row_addr,
    output frame_cnt_t   frame_count
);

    localparam col_t   LAST_COL   = col_t'(`LM_COLS - 1);
    localparam row_t   LAST_ROW   = row_t'(`LM_HALF_ROWS - 1);
    localparam plane_t LAST_PLANE = plane_t'(`LM_COLOR_BITS - 1);

    scan_state_t state;
    scan_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            IDLE:       state_next = FETCH;
            FETCH:      state_next = LOAD;
            LOAD:       state_next = SHIFT_LOW;
            SHIFT_LOW:  state_next = SHIFT_HIGH;
            // col already stepped in LOAD, back at 0 after the last one
            SHIFT_HIGH: state_next = (col == '0) ? BLANK : FETCH;
            BLANK:      state_next = LATCH;
            LATCH:      state_next = DISPLAY;
            DISPLAY: begin
                if (timer_done) begin
                    state_next = FETCH;
                end
            end
            default:    state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk_root) begin
        if (rst) begin
            state       <= IDLE;
            col         <= '0;
            row         <= '0;
            plane       <= '0;
            row_addr    <= '0;
            frame_count <= '0;
        end else begin
            state <= state_next;
            if (state == LOAD) begin
                col <= (col == LAST_COL) ? '0 : col + 1'b1;
            end
            if (state == LATCH) begin
                row_addr <= row;    // row just shifted in
                plane    <= (plane == LAST_PLANE) ? '0 : plane + 1'b1;
                if (plane == LAST_PLANE) begin
                    row <= (row == LAST_ROW) ? '0 : row + 1'b1;
                    if (row == LAST_ROW) begin
                        frame_count <= frame_count + 1'b1;  // wraps
                    end
                end
            end
        end
    end

    // address goes out a cycle ahead so the ram read happens in FETCH
    assign fetch       = (state_next == FETCH);
    assign load        = (state == LOAD);
    assign clk_pixel   = (state == SHIFT_HIGH);
    assign row_latch   = (state == LATCH);
    assign timer_start = (state == LATCH);  // plane still the latched one here
    assign oe_n        = (state != DISPLAY);

endmodule

`default_nettype wire

// File: logic/led_matrix_top.sv
// ====================
// HUB75 scan driver top, APB host port
// ====================
`default_nettype none

module led_matrix_top
    import led_matrix_pkg::*;
(
    input  wire           clk_root,
    input  wire           rst,
    input  wire           psel,
    input  wire           penable,
    input  wire           pwrite,
    input  wire    [11:0] paddr,
    input  wire    [31:0] pwdata,
    output logic   [31:0] prdata,
    output logic          pready,
    output logic          pslverr,
    output rgb_t          rgb_top,
    output rgb_t          rgb_bottom,
    output logic          clk_pixel,
    output logic          row_latch,
    output logic          oe_n,
    output row_t          row_addr
);

    // APB side of the framebuffer
    logic        fb_we;
    fb_addr_t    fb_addr;
    pixel_t      fb_wdata;
    pixel_t      fb_rdata;

    // scan side
    fb_addr_t    top_addr;
    fb_addr_t    bottom_addr;
    pixel_t      top_data;
    pixel_t      bottom_data;

    rgb_t        rgb_enable;
    plane_mask_t plane_enable;
    col_t        col;
    row_t        row;
    plane_t      plane;
    logic        fetch;
    logic        load;
    logic        timer_start;
    logic        timer_done;
    frame_cnt_t  frame_count;

    apb_regs i_apb_regs (
        .clk_root     (clk_root),
        .rst          (rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .fb_we        (fb_we),
        .fb_addr      (fb_addr),
        .fb_wdata     (fb_wdata),
        .fb_rdata     (fb_rdata),
        .rgb_enable   (rgb_enable),
        .plane_enable (plane_enable),
        .frame_count  (frame_count)
    );

    framebuffer i_framebuffer (
        .clk_root     (clk_root),
        .rst          (rst),
        .we           (fb_we),
        .addr         (fb_addr),
        .wdata        (fb_wdata),
        .rdata        (fb_rdata),
        .top_addr     (top_addr),
        .bottom_addr  (bottom_addr),
        .top_data     (top_data),
        .bottom_data  (bottom_data)
    );

    pixel_fetch i_pixel_fetch (
        .clk_root     (clk_root),
        .rst          (rst),
        .col          (col),
        .row          (row),
        .plane        (plane),
        .fetch        (fetch),
        .load         (load),
        .rgb_enable   (rgb_enable),
        .plane_enable (plane_enable),
        .top_addr     (top_addr),
        .bottom_addr  (bottom_addr),
        .top_data     (top_data),
        .bottom_data  (bottom_data),
        .rgb_top      (rgb_top),
        .rgb_bottom   (rgb_bottom)
    );

    plane_timer i_plane_timer (
        .clk_root     (clk_root),
        .rst          (rst),
        .start        (timer_start),
        .plane        (plane),
        .done         (timer_done)
    );

    matrix_scan i_matrix_scan (
        .clk_root     (clk_root),
        .rst          (rst),
        .timer_done   (timer_done),
        .col          (col),
        .row          (row),
        .plane        (plane),
        .fetch        (fetch),
        .load         (load),
        .timer_start  (timer_start),
        .clk_pixel    (clk_pixel),
        .row_latch    (row_latch),
        .oe_n         (oe_n),
        .row_addr     (row_addr),
        .frame_count  (frame_count)
    );

endmodule

`default_nettype wire

// File: verif/led_matrix_checker.sv
// ====================
// panel and APB timing assertions
// ====================
`default_nettype none

module led_matrix_checker
    import led_matrix_pkg::*;
(
    input  wire         clk_root,
    input  wire         rst,
    input  wire         psel,
    input  wire         penable,
    input  wire         pready,
    input  wire         clk_pixel,
    input  wire         row_latch,
    input  wire         oe_n,
    input  wire rgb_t   rgb_top,
    input  wire rgb_t   rgb_bottom
);

    int failures = 0;   // failed assertions so far

    // panel dark while the shifted row is latched
    assert property (@(posedge clk_root) disable iff (rst) row_latch |-> oe_n)
        else begin
            failures++;
            $error("oe_n low during row latch");
        end

    assert property (@(posedge clk_root) disable iff (rst)
        clk_pixel |-> ($stable(rgb_top) && $stable(rgb_bottom)))
        else begin
            failures++;
            $error("rgb outputs changed while clk_pixel high");
        end

    assert property (@(posedge clk_root) disable iff (rst) pready |-> (psel && penable))
        else begin
            failures++;
            $error("pready high outside an APB access");
        end

    assert property (@(posedge clk_root) disable iff (rst) !(clk_pixel && row_latch))
        else begin
            failures++;
            $error("clk_pixel and row_latch high together");
        end

endmodule

`default_nettype wire

// File: verif/led_matrix_monitor.sv
// ====================
// APB snoop with image model, panel bits
// compared per latched row/plane, oe_n timing
// ====================
`default_nettype none
`include "led_matrix_macros.svh"

module led_matrix_monitor
    import led_matrix_pkg::*;
(
    input  wire           clk_root,
    input  wire           rst,
    input  wire           psel,
    input  wire           penable,
    input  wire           pwrite,
    input  wire    [11:0] paddr,
    input  wire    [31:0] pwdata,
    input  wire           pready,
    input  wire rgb_t     rgb_top,
    input  wire rgb_t     rgb_bottom,
    input  wire           clk_pixel,
    input  wire           row_latch,
    input  wire           oe_n,
    input  wire row_t     row_addr,
    output int            error_count
);

    localparam int HALF_PIXELS = `LM_HALF_ROWS * `LM_COLS;

    pixel_t      image [2 * HALF_PIXELS];
    rgb_t        chan_en;
    plane_mask_t plane_en;
    rgb_t        top_seen [`LM_COLS];
    rgb_t        bottom_seen [`LM_COLS];
    int          col_seen;
    int          scan_row;      // row/plane being shifted now
    int          scan_plane;
    int          shown_row;
    int          shown_plane;
    int          oe_low;
    bit          in_display;
    bit          row_addr_due;
    bit          write_seen;    // APB write landed during this shift
    bit          clk_pixel_q;
    bit          row_latch_q;

    // one bit per channel, red in bit 0
    function automatic rgb_t expected_bits(input pixel_t px, input int pl,
                                           input rgb_t en, input plane_mask_t pen);
        rgb_t bits;
        for (int ch = 0; ch < 3; ch++) begin
            bits[ch] = px[(2 - ch) * `LM_COLOR_BITS + pl] & en[ch] & pen[pl];
        end
        return bits;
    endfunction

    task automatic report_mismatch(input string name, input int col,
                                   input rgb_t exp, input rgb_t got);
        error_count++;
        $display("mismatch at %0t: %s row %0d plane %0d col %0d expected %0h got %0h",
                 $time, name, scan_row, scan_plane, col, exp, got);
    endtask

    task automatic compare_row();
        rgb_t exp_top;
        rgb_t exp_bottom;
        int   base;
        base = scan_row * `LM_COLS;
        for (int c = 0; c < `LM_COLS; c++) begin
            exp_top    = expected_bits(image[base + c], scan_plane, chan_en, plane_en);
            exp_bottom = expected_bits(image[HALF_PIXELS + base + c], scan_plane,
                                       chan_en, plane_en);
            if (top_seen[c] !== exp_top) report_mismatch("rgb_top", c, exp_top, top_seen[c]);
            if (bottom_seen[c] !== exp_bottom) begin
                report_mismatch("rgb_bottom", c, exp_bottom, bottom_seen[c]);
            end
        end
    endtask

    // negedge sampling, all panel and APB signals settled
    always @(negedge clk_root) begin
        if (rst) begin
            for (int i = 0; i < 2 * HALF_PIXELS; i++) image[i] = '0;
            chan_en      = '1;
            plane_en     = '1;
            col_seen     = 0;
            scan_row     = 0;
            scan_plane   = 0;
            in_display   = 1'b0;
            row_addr_due = 1'b0;
            write_seen   = 1'b0;
            clk_pixel_q  = 1'b0;
            row_latch_q  = 1'b0;
        end else begin
            if (row_addr_due && row_addr !== row_t'(shown_row)) begin
                error_count++;
                $display("mismatch at %0t: row_addr expected %0d got %0d",
                         $time, shown_row, row_addr);
            end
            row_addr_due = 1'b0;
            if (in_display && !oe_n) begin
                oe_low++;
            end else if (in_display) begin
                in_display = 1'b0;
                if (oe_low != (`LM_PLANE_BASE_TICKS << shown_plane)) begin
                    error_count++;
                    $display("mismatch at %0t: oe_n low cycles plane %0d expected %0d got %0d",
                             $time, shown_plane, `LM_PLANE_BASE_TICKS << shown_plane, oe_low);
                end
            end
            // write commits on the next rising edge
            if (psel && penable && pready && pwrite) begin
                write_seen = 1'b1;
                if (paddr < `LM_CTRL_ADDR && paddr[1:0] == 2'b00) begin
                    image[paddr[9:2]] = pixel_t'(pwdata);
                end else if (paddr == `LM_CTRL_ADDR) begin
                    chan_en  = pwdata[2:0];
                    plane_en = pwdata[7:4];
                end
            end
            if (clk_pixel && !clk_pixel_q) begin
                if (col_seen < `LM_COLS) begin
                    top_seen[col_seen]    = rgb_top;
                    bottom_seen[col_seen] = rgb_bottom;
                end
                col_seen++;
            end
            if (row_latch && !row_latch_q) begin
                if (col_seen != `LM_COLS) begin
                    error_count++;
                    $display("row latch at %0t came after %0d pixel clocks instead of %0d",
                             $time, col_seen, `LM_COLS);
                end else if (!write_seen) begin
                    compare_row();
                end
                shown_row    = scan_row;
                shown_plane  = scan_plane;
                row_addr_due = 1'b1;
                in_display   = 1'b1;
                oe_low       = 0;
                scan_plane   = (scan_plane + 1) % `LM_COLOR_BITS;
                if (scan_plane == 0) scan_row = (scan_row + 1) % `LM_HALF_ROWS;
                col_seen     = 0;
                write_seen   = 1'b0;
            end
            clk_pixel_q = clk_pixel;
            row_latch_q = row_latch;
        end
    end

endmodule

`default_nettype wire

// File: verif/led_matrix_tb.sv
// ====================
// testbench top with clock, reset, APB stimulus
// from the vectors file, watchdog and report
// ====================
`default_nettype none
`include "led_matrix_macros.svh"

module led_matrix_tb
    import led_matrix_pkg::*;
();

    localparam int MAX_VECTORS       = 64;
    localparam int FIELDS            = 5;   // op, addr, data, exp_data, exp_err
    localparam int LATCHES_PER_FRAME = `LM_HALF_ROWS * `LM_COLOR_BITS;

    logic        clk_root;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    rgb_t        rgb_top;
    rgb_t        rgb_bottom;
    logic        clk_pixel;
    logic        row_latch;
    logic        oe_n;
    row_t        row_addr;

    logic [31:0] vectors [MAX_VECTORS * FIELDS];
    logic [31:0] fill_words [2 * `LM_HALF_ROWS * `LM_COLS];
    int          seed;
    int          errors;
    int          monitor_errors;
    int          vector_count;
    int          watchdog_cycles;
    bit          watchdog_armed;

    initial clk_root = 1'b0;
    always #2 clk_root = ~clk_root;

    led_matrix_top i_led_matrix_top (
        .clk_root   (clk_root),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .rgb_top    (rgb_top),
        .rgb_bottom (rgb_bottom),
        .clk_pixel  (clk_pixel),
        .row_latch  (row_latch),
        .oe_n       (oe_n),
        .row_addr   (row_addr)
    );

    led_matrix_monitor i_monitor (
        .clk_root    (clk_root),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .pready      (pready),
        .rgb_top     (rgb_top),
        .rgb_bottom  (rgb_bottom),
        .clk_pixel   (clk_pixel),
        .row_latch   (row_latch),
        .oe_n        (oe_n),
        .row_addr    (row_addr),
        .error_count (monitor_errors)
    );

    bind led_matrix_top led_matrix_checker i_checker (
        .clk_root   (clk_root),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pready     (pready),
        .clk_pixel  (clk_pixel),
        .row_latch  (row_latch),
        .oe_n       (oe_n),
        .rgb_top    (rgb_top),
        .rgb_bottom (rgb_bottom)
    );

    function automatic int frame_cycles();
        int total;
        total = 0;
        for (int p = 0; p < `LM_COLOR_BITS; p++) begin
            total += 4 * `LM_COLS + 2 + (`LM_PLANE_BASE_TICKS << p);  // shift, blank, latch
        end
        return total * `LM_HALF_ROWS;
    endfunction

    task automatic check_value(input string name, input logic [11:0] addr,
                               input logic [31:0] exp, input logic [31:0] got);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s addr %03h expected %08h got %08h",
                     $time, name, addr, exp, got);
        end
    endtask

    // one setup and two access cycles with inputs moved 1 unit after the edge
    task automatic apb_transfer(input logic write, input logic [11:0] addr,
                                input logic [31:0] data, output logic [31:0] rdata,
                                output logic err);
        int access_cycles;
        @(posedge clk_root);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk_root);
        #1;
        penable       = 1'b1;
        access_cycles = 1;
        while (!pready && access_cycles < 8) begin
            @(posedge clk_root);
            #1;
            access_cycles++;
        end
        if (access_cycles != 2) begin
            errors++;
            $display("APB access at %03h took %0d cycles instead of 2", addr, access_cycles);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk_root);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic wait_frames(input int frames);
        repeat (frames * LATCHES_PER_FRAME) begin
            @(negedge clk_root);
            while (!row_latch) @(negedge clk_root);
        end
    endtask

    task automatic random_fill(input logic [11:0] base, input int count);
        logic [31:0] rdata;
        logic        err;
        logic [11:0] addr;
        for (int i = 0; i < count; i++) begin
            fill_words[i] = $random(seed);  // upper bits are dropped by the DUT
            addr = base + 12'(4 * i);
            apb_transfer(1'b1, addr, fill_words[i], rdata, err);
            check_value("pslverr", addr, 32'h0, {31'b0, err});
        end
        for (int i = 0; i < count; i++) begin
            addr = base + 12'(4 * i);
            apb_transfer(1'b0, addr, 32'h0, rdata, err);
            check_value("prdata", addr, {20'b0, fill_words[i][11:0]}, rdata);
        end
    endtask

    task automatic check_frame_growth(input int frames);
        logic [31:0] first;
        logic [31:0] second;
        logic [15:0] delta;
        logic        err;
        apb_transfer(1'b0, `LM_STATUS_ADDR, 32'h0, first, err);
        check_value("pslverr", `LM_STATUS_ADDR, 32'h0, {31'b0, err});
        wait_frames(frames);
        apb_transfer(1'b0, `LM_STATUS_ADDR, 32'h0, second, err);
        check_value("pslverr", `LM_STATUS_ADDR, 32'h0, {31'b0, err});
        delta = second[15:0] - first[15:0];   // counter wraps at 16 bits
        if (int'(delta) < frames) begin
            errors++;
            $display("frame count grew by %0d over %0d frames", delta, frames);
        end
    endtask

    task automatic run_vector(input int v);
        logic [31:0] op;
        logic [11:0] addr;
        logic [31:0] data;
        logic [31:0] exp_data;
        logic [31:0] exp_err;
        logic [31:0] rdata;
        logic        err;
        op       = vectors[v * FIELDS];
        addr     = vectors[v * FIELDS + 1][11:0];
        data     = vectors[v * FIELDS + 2];
        exp_data = vectors[v * FIELDS + 3];
        exp_err  = vectors[v * FIELDS + 4];
        case (op)
            32'h0, 32'h1: begin
                apb_transfer(op == 32'h0, addr, data, rdata, err);
                check_value("pslverr", addr, exp_err, {31'b0, err});
                if (op == 32'h1 && exp_err == 32'h0) check_value("prdata", addr, exp_data, rdata);
            end
            32'h2: wait_frames(int'(data));
            32'h3: random_fill(addr, int'(data));
            32'h4: check_frame_growth(int'(data));
            default: begin
                errors++;
                $display("vector %0d has unknown operation %0h", v, op);
            end
        endcase
    endtask

    task automatic finish_run(input bit timed_out);
        int checker_errors;
        checker_errors = i_led_matrix_top.i_checker.failures;
        $display("errors: testbench %0d, monitor %0d, checker %0d",
                 errors, monitor_errors, checker_errors);
        if (timed_out || errors != 0 || monitor_errors != 0 || checker_errors != 0) begin
            $display("FAIL: see errors above");
        end else begin
            $display("PASS: all tests");
        end
        $finish;
    endtask

    initial begin
        int transfers;
        int frames;
        logic [31:0] op;
        logic [31:0] data;
        seed           = 32'hd98f4dba;
        errors         = 0;
        transfers      = 0;
        frames         = 0;
        vector_count   = 0;
        watchdog_armed = 1'b0;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        for (int i = 0; i < MAX_VECTORS * FIELDS; i++) vectors[i] = 32'hf;
        $readmemh("verif/led_matrix_vectors.txt", vectors);
        while (vector_count < MAX_VECTORS && vectors[vector_count * FIELDS] != 32'hf) begin
            op   = vectors[vector_count * FIELDS];
            data = vectors[vector_count * FIELDS + 2];
            case (op)
                32'h2: frames += int'(data);
                32'h3: transfers += 2 * int'(data);
                32'h4: begin
                    transfers += 2;
                    frames    += int'(data);
                end
                default: transfers += 1;
            endcase
            vector_count++;
        end
        watchdog_cycles = transfers * 10 + frames * frame_cycles() + 1000;
        watchdog_armed  = 1'b1;
        repeat (16) @(posedge clk_root);
        #1;
        rst = 1'b0;
        for (int v = 0; v < vector_count; v++) run_vector(v);
        finish_run(1'b0);
    end

    initial begin
        wait (watchdog_armed);
        repeat (watchdog_cycles) @(posedge clk_root);
        $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
        finish_run(1'b1);
    end

endmodule

`default_nettype wire

// File: verif/led_matrix_vectors.txt
// op addr data exp_data exp_err, all hex; op 0 write, 1 read, 2 wait data frames
// op 3 random fill of data words from addr, op 4 frame count grows by data frames, f end
1 404 0 0 0
0 404 ffff 0 0
1 404 0 0 0
1 400 0 f7 0
1 000 0 0 0
1 0fc 0 0 0
1 3fc 0 0 0
2 000 1 0 0
0 408 1234 0 1
1 408 0 0 1
0 802 5a5 0 1
0 002 abc 0 1
1 000 0 0 0
1 400 0 f7 0
0 000 fedcbabc 0 0
1 000 0 abc 0
0 3fc 5a5 0 0
1 3fc 0 5a5 0
3 000 100 0 0
2 000 2 0 0
0 400 a5 0 0
1 400 0 a5 0
2 000 1 0 0
0 400 f0 0 0
2 000 1 0 0
0 400 ffffff77 0 0
1 400 0 77 0
2 000 1 0 0
0 400 f7 0 0
4 000 2 0 0
f 0 0 0 0

// File: led_matrix_top.f
+incdir+logic
logic/led_matrix_pkg.sv
logic/apb_regs.sv
logic/framebuffer.sv
logic/plane_timer.sv
logic/pixel_fetch.sv
logic/matrix_scan.sv
logic/led_matrix_top.sv
verif/led_matrix_checker.sv
verif/led_matrix_monitor.sv
verif/led_matrix_tb.sv

// File: run.sh
#!/bin/sh
# build the led matrix testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module led_matrix_tb \
    --Mdir obj_dir -f led_matrix_top.f || { echo "verilator build failed"; exit 1; }
./obj_dir/Vled_matrix_tb 2>&1 | tee sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
exit 0
